/* files.f */
+incdir+design
design/brisc_pkg.sv
design/ex_result_if.sv
design/reg_file.sv
design/alu.sv
design/hazard_unit.sv
design/alu_stage.sv
design/commit_stages.sv
design/brisc_exec_top.sv
bench/brisc_exec_chk.sv
bench/brisc_exec_tb.sv

/* Makefile */
TOP := brisc_exec_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o sim
	./obj_dir/sim +verilator+error+limit+100 | tee sim.log
	@if grep -q "Testbench failed" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Testbench passed" sim.log || (echo "Simulation gave no result"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* bench/brisc_exec_tb.sv */
`timescale 1ns/1ps
`include "brisc_config.svh"

module brisc_exec_tb;
  import brisc_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RAND_OPS   = 200;
  localparam int TOTAL_OPS  = 80 + RAND_OPS;

  typedef struct packed {
    word_t       pc;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    word_t       imm;
    alu_ctrl_e   ctrl;
    alu_src_e    src;
    result_src_e rsrc;
    logic        rw;
    logic        mw;
    logic        br;
    logic        jmp;
    data_size_e  size;
  } op_t;

  logic        clk;
  logic        arst_n;
  logic        issue;
  logic        stall;
  word_t       pc;
  reg_idx_t    rd;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  word_t       imm;
  alu_ctrl_e   alu_ctrl;
  alu_src_e    alu_src;
  result_src_e result_src;
  logic        reg_write;
  logic        mem_write;
  logic        is_branch;
  logic        is_jump;
  data_size_e  data_size;
  pc_src_e     pc_src;
  word_t       pc_target;
  logic        mem_we;
  word_t       mem_addr;
  word_t       mem_wdata;
  data_size_e  mem_size;
  xcpt_e       xcpt;
  logic        wb_en;
  reg_idx_t    wb_rd;
  word_t       wb_data;

  // Architectural state of the reference model
  word_t      arch [32];
  logic       squash_next;
  word_t      next_pc;
  int         errors;
  int         tests_failed;
  int         tests_run;

  // Op leaving execute in the current cycle
  logic       ex_taken;
  logic       ex_store;
  logic       ex_wb;
  logic       next_store;
  logic       next_wb;

  reg_idx_t   q_wb_rd [$];
  word_t      q_wb_data [$];
  word_t      q_st_addr [$];
  word_t      q_st_data [$];
  data_size_e q_st_size [$];
  xcpt_e      q_st_xcpt [$];
  word_t      q_target [$];

  brisc_exec_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic compare_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_idx(string name, reg_idx_t got, reg_idx_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_size(string name, data_size_e got, data_size_e exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %s, expected %s", $time, name, got.name(), exp.name());
      errors++;
    end
  endtask

  task automatic compare_xcpt(string name, xcpt_e got, xcpt_e exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %s, expected %s", $time, name, got.name(), exp.name());
      errors++;
    end
  endtask

  task automatic compare_pc_src(string name, pc_src_e got, pc_src_e exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %s, expected %s", $time, name, got.name(), exp.name());
      errors++;
    end
  endtask

  function automatic word_t ref_alu(alu_ctrl_e c, word_t a, word_t b);
    case (c)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      SLL:     return a << b[4:0];
      default: return a >> b[4:0];
    endcase
  endfunction

  // Steps the register array through one op, queues its effects, returns taken
  function automatic logic model_op(op_t op);
    word_t a;
    word_t b;
    word_t r;
    word_t wv;
    logic  taken;
    a = arch[op.rs1];
    b = (op.src == FROM_IMM) ? op.imm : arch[op.rs2];
    r = ref_alu(op.ctrl, a, b);
    taken = op.jmp || (op.br && r == '0);
    if (taken) q_target.push_back(op.pc + op.imm);
    if (op.mw) begin
      q_st_addr.push_back(r);
      q_st_data.push_back(arch[op.rs2]);
      q_st_size.push_back(op.size);
      if (op.size == W && r[1:0] != 2'b00) q_st_xcpt.push_back(MEM_UNALIGNED);
      else if (r < `PC_DATA) q_st_xcpt.push_back(ADDR_INVALID);
      else q_st_xcpt.push_back(NO_XCPT);
    end
    if (op.rw && op.rd != '0) begin
      wv = (op.rsrc == RES_PC4) ? op.pc + 32'd4 : r;
      arch[op.rd] = wv;
      q_wb_rd.push_back(op.rd);
      q_wb_data.push_back(wv);
    end
    return taken;
  endfunction

  function automatic op_t mk(alu_ctrl_e c, reg_idx_t d, reg_idx_t s1, reg_idx_t s2,
                             word_t im, alu_src_e src);
    op_t op;
    op.pc   = next_pc;
    op.rd   = d;
    op.rs1  = s1;
    op.rs2  = s2;
    op.imm  = im;
    op.ctrl = c;
    op.src  = src;
    op.rsrc = RES_ALU;
    op.rw   = 1'b1;
    op.mw   = 1'b0;
    op.br   = 1'b0;
    op.jmp  = 1'b0;
    op.size = W;
    next_pc = next_pc + 32'd4;
    return op;
  endfunction

  task automatic drive(op_t op, logic do_issue, logic do_stall);
    logic taken;
    @(posedge clk);
    issue      <= do_issue;
    stall      <= do_stall;
    pc         <= op.pc;
    rd         <= op.rd;
    rs1        <= op.rs1;
    rs2        <= op.rs2;
    imm        <= op.imm;
    alu_ctrl   <= op.ctrl;
    alu_src    <= op.src;
    result_src <= op.rsrc;
    reg_write  <= op.rw;
    mem_write  <= op.mw;
    is_branch  <= op.br;
    is_jump    <= op.jmp;
    data_size  <= op.size;
    // Stalled cycles drop the issue and keep a pending squash
    if (!do_stall) begin
      // Op from the last unstalled cycle leaves execute in this one
      ex_taken   = squash_next;
      ex_store   = next_store;
      ex_wb      = next_wb;
      taken      = 1'b0;
      next_store = 1'b0;
      next_wb    = 1'b0;
      if (do_issue && !squash_next) begin
        taken      = model_op(op);
        next_store = op.mw;
        next_wb    = op.rw && op.rd != '0;
      end
      squash_next = taken;
    end
  endtask

  task automatic run_alu(alu_ctrl_e c, reg_idx_t d, reg_idx_t s1, reg_idx_t s2,
                         word_t im, alu_src_e src);
    drive(mk(c, d, s1, s2, im, src), 1'b1, 1'b0);
  endtask

  task automatic run_branch(reg_idx_t s1, reg_idx_t s2, word_t im);
    op_t op;
    op = mk(SUB, 5'd0, s1, s2, im, FROM_REG);
    op.rw = 1'b0;
    op.br = 1'b1;
    drive(op, 1'b1, 1'b0);
  endtask

  task automatic run_jump(reg_idx_t d, word_t im);
    op_t op;
    op = mk(ADD, d, 5'd0, 5'd0, im, FROM_IMM);
    op.jmp  = 1'b1;
    op.rsrc = RES_PC4;
    drive(op, 1'b1, 1'b0);
  endtask

  task automatic run_store(reg_idx_t s1, reg_idx_t s2, word_t im, data_size_e sz);
    op_t op;
    op = mk(ADD, 5'd0, s1, s2, im, FROM_IMM);
    op.rw   = 1'b0;
    op.mw   = 1'b1;
    op.size = sz;
    drive(op, 1'b1, 1'b0);
  endtask

  task automatic idle(int n);
    repeat (n) drive(mk(ADD, 5'd0, 5'd0, 5'd0, '0, FROM_IMM), 1'b0, 1'b0);
  endtask

  function automatic op_t rand_op();
    op_t op;
    int  kind;
    kind = int'($urandom % 10);
    op = mk(alu_ctrl_e'(3'($urandom % 8)), reg_idx_t'($urandom % 8),
            reg_idx_t'($urandom % 8), reg_idx_t'($urandom % 8), $urandom,
            alu_src_e'(1'($urandom % 2)));
    if (kind == 0) begin
      op.ctrl = SUB;
      op.src  = FROM_REG;
      op.rw   = 1'b0;
      op.br   = 1'b1;
    end else if (kind == 1) begin
      op.jmp  = 1'b1;
      op.rsrc = RES_PC4;
    end else if (kind == 2) begin
      op.ctrl = ADD;
      op.src  = FROM_IMM;
      op.imm  = word_t'($urandom % 32'h400);
      op.rw   = 1'b0;
      op.mw   = 1'b1;
      op.size = data_size_e'(2'($urandom % 3));
    end
    return op;
  endfunction

  task automatic end_test(string name, int err_start);
    idle(6);
    if (q_wb_rd.size() + q_st_addr.size() + q_target.size() != 0) begin
      $display("Expected events never appeared in test %s", name);
      errors++;
    end
    tests_run++;
    if (errors != err_start) tests_failed++;
    $display("Test %s: %0d errors", name, errors - err_start);
  endtask

  // Checks every cycle at the fixed execute, C and WB latencies
  initial begin
    logic  st_due;
    logic  wb_c;
    logic  wb_due;
    xcpt_e exp_x;
    st_due = 1'b0;
    wb_c   = 1'b0;
    wb_due = 1'b0;
    @(posedge arst_n);
    forever begin
      @(negedge clk);
      if (wb_due) begin
        compare_bit("wb_en", wb_en, 1'b1);
        compare_idx("wb_rd", wb_rd, q_wb_rd.pop_front());
        compare_word("wb_data", wb_data, q_wb_data.pop_front());
      end else begin
        compare_bit("wb_en", wb_en, 1'b0);
      end
      if (st_due) begin
        exp_x = q_st_xcpt.pop_front();
        compare_xcpt("xcpt", xcpt, exp_x);
        compare_bit("mem_we", mem_we, exp_x == NO_XCPT);
        compare_word("mem_addr", mem_addr, q_st_addr.pop_front());
        compare_word("mem_wdata", mem_wdata, q_st_data.pop_front());
        compare_size("mem_size", mem_size, q_st_size.pop_front());
      end else begin
        compare_xcpt("xcpt", xcpt, NO_XCPT);
        compare_bit("mem_we", mem_we, 1'b0);
      end
      if (!stall) begin
        compare_pc_src("pc_src", pc_src, ex_taken ? PC_TARGET : PC_SEQ);
        if (ex_taken) begin
          compare_word("pc_target", pc_target, q_target.pop_front());
        end
      end
      // A stalled execute sends a bubble into C
      wb_due = wb_c;
      wb_c   = !stall && ex_wb;
      st_due = !stall && ex_store;
    end
  end

  initial begin
    #((TOTAL_OPS * 4 + 200) * CLK_PERIOD);
    $display("Timeout: the tests did not finish in time");
    $display("Testbench failed");
    $finish;
  end

  initial begin
    int e0;
    void'($urandom(2));
    arst_n = 1'b0;
    issue = 1'b0;
    stall = 1'b0;
    pc = '0;
    rd = '0;
    rs1 = '0;
    rs2 = '0;
    imm = '0;
    alu_ctrl = ADD;
    alu_src = FROM_REG;
    result_src = RES_ALU;
    reg_write = 1'b0;
    mem_write = 1'b0;
    is_branch = 1'b0;
    is_jump = 1'b0;
    data_size = W;
    squash_next = 1'b0;
    ex_taken = 1'b0;
    ex_store = 1'b0;
    ex_wb = 1'b0;
    next_store = 1'b0;
    next_wb = 1'b0;
    next_pc = 32'h1000;
    errors = 0;
    tests_failed = 0;
    tests_run = 0;
    for (int i = 0; i < 32; i++) arch[i] = '0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;

    e0 = errors;
    run_alu(ADD, 5'd1, 5'd0, 5'd0, 32'h0000_1234, FROM_IMM);
    run_alu(ADD, 5'd2, 5'd0, 5'd0, 32'hFFFF_FFF0, FROM_IMM);
    run_alu(ADD, 5'd3, 5'd0, 5'd0, 32'd5, FROM_IMM);
    run_alu(ADD, 5'd4, 5'd0, 5'd0, 32'h0F0F_00FF, FROM_IMM);
    idle(3);
    run_alu(SUB, 5'd5, 5'd1, 5'd2, '0, FROM_REG);
    run_alu(AND, 5'd6, 5'd1, 5'd4, '0, FROM_REG);
    run_alu(OR, 5'd7, 5'd2, 5'd0, 32'h0000_000F, FROM_IMM);
    run_alu(XOR, 5'd8, 5'd4, 5'd1, '0, FROM_REG);
    run_alu(SLT, 5'd9, 5'd2, 5'd1, '0, FROM_REG);
    run_alu(SLT, 5'd10, 5'd1, 5'd0, 32'h10, FROM_IMM);
    run_alu(SLL, 5'd11, 5'd1, 5'd3, '0, FROM_REG);
    run_alu(SRL, 5'd12, 5'd2, 5'd0, 32'd4, FROM_IMM);
    end_test("independent_alu", e0);

    // Distances one, two and three
    e0 = errors;
    run_alu(ADD, 5'd20, 5'd0, 5'd0, 32'd1, FROM_IMM);
    run_alu(ADD, 5'd21, 5'd20, 5'd20, '0, FROM_REG);
    run_alu(ADD, 5'd22, 5'd20, 5'd21, '0, FROM_REG);
    run_alu(ADD, 5'd23, 5'd20, 5'd0, 32'd1, FROM_IMM);
    run_alu(SLL, 5'd24, 5'd21, 5'd22, '0, FROM_REG);
    idle(1);
    run_alu(XOR, 5'd25, 5'd24, 5'd23, '0, FROM_REG);
    run_alu(ADD, 5'd0, 5'd1, 5'd0, 32'd5, FROM_IMM);
    run_alu(ADD, 5'd26, 5'd0, 5'd0, 32'd1, FROM_IMM);
    end_test("forwarding", e0);

    e0 = errors;
    run_branch(5'd1, 5'd1, 32'h40);
    run_alu(ADD, 5'd27, 5'd0, 5'd0, 32'hDEAD, FROM_IMM);
    run_alu(ADD, 5'd28, 5'd0, 5'd0, 32'd1, FROM_IMM);
    run_branch(5'd1, 5'd2, 32'h80);
    run_alu(ADD, 5'd27, 5'd0, 5'd0, 32'h55, FROM_IMM);
    run_jump(5'd31, 32'h100);
    run_alu(ADD, 5'd29, 5'd0, 5'd0, 32'hBAD, FROM_IMM);
    run_alu(ADD, 5'd30, 5'd31, 5'd0, 32'd8, FROM_IMM);
    run_jump(5'd0, 32'hFFFF_FF00);
    run_alu(ADD, 5'd30, 5'd0, 5'd0, 32'hBAD, FROM_IMM);
    end_test("branch_jump", e0);

    e0 = errors;
    run_alu(ADD, 5'd5, 5'd0, 5'd0, 32'h200, FROM_IMM);
    run_alu(ADD, 5'd6, 5'd0, 5'd0, 32'hCAFE_F00D, FROM_IMM);
    run_store(5'd5, 5'd6, 32'd0, W);
    run_store(5'd5, 5'd6, 32'd2, H);
    run_store(5'd5, 5'd6, 32'd3, B);
    run_store(5'd5, 5'd6, 32'd2, W);
    run_store(5'd0, 5'd6, 32'h40, W);
    run_store(5'd0, 5'd6, 32'h41, H);
    end_test("stores", e0);

    e0 = errors;
    for (int i = 0; i < RAND_OPS; i++) begin
      drive(rand_op(), ($urandom % 4) != 0, ($urandom % 4) == 0);
    end
    end_test("random_stalls", e0);

    if (uut.u_chk.fail_cnt != 0) begin
      $display("%0d assertion failures in the bound checker", uut.u_chk.fail_cnt);
      errors += uut.u_chk.fail_cnt;
    end
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* bench/brisc_exec_chk.sv */
`timescale 1ns/1ps

module brisc_exec_chk (
  input logic                clk,
  input logic                arst_n,
  input logic                wb_en,
  input brisc_pkg::reg_idx_t wb_rd,
  input logic                mem_we,
  input brisc_pkg::xcpt_e    xcpt,
  input brisc_pkg::pc_src_e  pc_src
);
  import brisc_pkg::*;

  int fail_cnt = 0;

  no_wb_r0: assert property (@(posedge clk) disable iff (!arst_n) wb_en |-> wb_rd != '0)
    else begin
      $error("writeback issued for register 0");
      fail_cnt++;
    end

  // A faulting store must never reach memory
  no_store_on_xcpt: assert property (@(posedge clk) disable iff (!arst_n)
                                     xcpt != NO_XCPT |-> !mem_we)
    else begin
      $error("store enabled while an exception is flagged");
      fail_cnt++;
    end

  quiet_after_reset: assert property (@(posedge clk) $rose(arst_n) |->
                                      !wb_en && !mem_we && xcpt == NO_XCPT && pc_src == PC_SEQ)
    else begin
      $error("outputs active right after reset");
      fail_cnt++;
    end

endmodule

bind brisc_exec_top brisc_exec_chk u_chk (.*);

/* design/brisc_exec_top.sv */
`timescale 1ns/1ps

module brisc_exec_top (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   issue,
  input  brisc_pkg::word_t       pc,
  input  brisc_pkg::reg_idx_t    rd,
  input  brisc_pkg::reg_idx_t    rs1,
  input  brisc_pkg::reg_idx_t    rs2,
  input  brisc_pkg::word_t       imm,
  input  brisc_pkg::alu_ctrl_e   alu_ctrl,
  input  brisc_pkg::alu_src_e    alu_src,
  input  brisc_pkg::result_src_e result_src,
  input  logic                   reg_write,
  input  logic                   mem_write,
  input  logic                   is_branch,
  input  logic                   is_jump,
  input  brisc_pkg::data_size_e  data_size,
  input  logic                   stall,
  output brisc_pkg::pc_src_e     pc_src,
  output brisc_pkg::word_t       pc_target,
  output logic                   mem_we,
  output brisc_pkg::word_t       mem_addr,
  output brisc_pkg::word_t       mem_wdata,
  output brisc_pkg::data_size_e  mem_size,
  output brisc_pkg::xcpt_e       xcpt,
  output logic                   wb_en,
  output brisc_pkg::reg_idx_t    wb_rd,
  output brisc_pkg::word_t       wb_data
);
  import brisc_pkg::*;

  word_t    rs1_data;
  word_t    rs2_data;
  word_t    alu_res_c;
  word_t    result_wb;
  reg_idx_t ex_rs1;
  reg_idx_t ex_rs2;
  reg_idx_t c_rd;
  logic     c_reg_write;
  fwd_src_e fwd_src1;
  fwd_src_e fwd_src2;
  logic     squash;

  ex_result_if ex_res ();

  reg_file u_reg_file (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb_en    (wb_en),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  hazard_unit u_hazard_unit (
    .ex_rs1       (ex_rs1),
    .ex_rs2       (ex_rs2),
    .c_rd         (c_rd),
    .wb_rd        (wb_rd),
    .c_reg_write  (c_reg_write),
    .wb_reg_write (wb_en),
    .pc_src       (pc_src),
    .fwd_src1     (fwd_src1),
    .fwd_src2     (fwd_src2),
    .squash       (squash)
  );

  alu_stage u_alu_stage (
    .clk        (clk),
    .arst_n     (arst_n),
    .squash     (squash),
    .stall      (stall),
    .issue      (issue),
    .fwd_src1   (fwd_src1),
    .fwd_src2   (fwd_src2),
    .pc         (pc),
    .rd         (rd),
    .rs1        (rs1),
    .rs2        (rs2),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .imm        (imm),
    .alu_ctrl   (alu_ctrl),
    .alu_src    (alu_src),
    .result_src (result_src),
    .reg_write  (reg_write),
    .mem_write  (mem_write),
    .is_branch  (is_branch),
    .is_jump    (is_jump),
    .data_size  (data_size),
    .alu_res_c  (alu_res_c),
    .result_wb  (result_wb),
    .pc_src     (pc_src),
    .pc_target  (pc_target),
    .ex_rs1     (ex_rs1),
    .ex_rs2     (ex_rs2),
    .res        (ex_res.ex)
  );

  commit_stages u_commit_stages (
    .clk         (clk),
    .arst_n      (arst_n),
    .res         (ex_res.cm),
    .alu_res_c   (alu_res_c),
    .result_wb   (result_wb),
    .c_reg_write (c_reg_write),
    .c_rd        (c_rd),
    .wb_en       (wb_en),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .mem_write   (mem_we),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_size    (mem_size),
    .xcpt        (xcpt)
  );

endmodule

/* design/commit_stages.sv */
`timescale 1ns/1ps

module commit_stages (
  input  logic                  clk,
  input  logic                  arst_n,
  ex_result_if.cm               res,
  output brisc_pkg::word_t      alu_res_c,
  output brisc_pkg::word_t      result_wb,
  output logic                  c_reg_write,
  output brisc_pkg::reg_idx_t   c_rd,
  output logic                  wb_en,
  output brisc_pkg::reg_idx_t   wb_rd,
  output brisc_pkg::word_t      wb_data,
  output logic                  mem_write,
  output brisc_pkg::word_t      mem_addr,
  output brisc_pkg::word_t      mem_wdata,
  output brisc_pkg::data_size_e mem_size,
  output brisc_pkg::xcpt_e      xcpt
);
  import brisc_pkg::*;

  word_t       c_pc_plus4;
  result_src_e c_result_src;
  word_t       wb_alu_res;
  word_t       wb_pc_plus4;
  result_src_e wb_result_src;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      c_reg_write <= 1'b0;
      mem_write   <= 1'b0;
      xcpt        <= NO_XCPT;
      wb_en       <= 1'b0;
    end else begin
      c_reg_write <= res.reg_write && res.rd != '0;
      // Faulting stores stay visible but never write
      mem_write   <= res.mem_write && res.xcpt == NO_XCPT;
      xcpt        <= res.xcpt;
      wb_en       <= c_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    c_rd          <= res.rd;
    mem_addr      <= res.alu_res;
    c_pc_plus4    <= res.pc_plus4;
    c_result_src  <= res.result_src;
    mem_wdata     <= res.write_data;
    mem_size      <= res.data_size;
    wb_rd         <= c_rd;
    wb_alu_res    <= mem_addr;
    wb_pc_plus4   <= c_pc_plus4;
    wb_result_src <= c_result_src;
  end

  // Jumps forward their link value
  assign alu_res_c = (c_result_src == RES_PC4) ? c_pc_plus4 : mem_addr;
  assign result_wb = (wb_result_src == RES_PC4) ? wb_pc_plus4 : wb_alu_res;
  assign wb_data   = result_wb;

endmodule

/* design/alu_stage.sv */
`timescale 1ns/1ps
`include "brisc_config.svh"

module alu_stage (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   squash,
  input  logic                   stall,
  input  logic                   issue,
  input  brisc_pkg::fwd_src_e    fwd_src1,
  input  brisc_pkg::fwd_src_e    fwd_src2,
  input  brisc_pkg::word_t       pc,
  input  brisc_pkg::reg_idx_t    rd,
  input  brisc_pkg::reg_idx_t    rs1,
  input  brisc_pkg::reg_idx_t    rs2,
  input  brisc_pkg::word_t       rs1_data,
  input  brisc_pkg::word_t       rs2_data,
  input  brisc_pkg::word_t       imm,
  input  brisc_pkg::alu_ctrl_e   alu_ctrl,
  input  brisc_pkg::alu_src_e    alu_src,
  input  brisc_pkg::result_src_e result_src,
  input  logic                   reg_write,
  input  logic                   mem_write,
  input  logic                   is_branch,
  input  logic                   is_jump,
  input  brisc_pkg::data_size_e  data_size,
  input  brisc_pkg::word_t       alu_res_c,
  input  brisc_pkg::word_t       result_wb,
  output brisc_pkg::pc_src_e     pc_src,
  output brisc_pkg::word_t       pc_target,
  output brisc_pkg::reg_idx_t    ex_rs1,
  output brisc_pkg::reg_idx_t    ex_rs2,
  ex_result_if.ex                res
);
  import brisc_pkg::*;

  logic        reg_write_q;
  logic        mem_write_q;
  logic        is_branch_q;
  logic        is_jump_q;
  word_t       pc_q;
  reg_idx_t    rd_q;
  reg_idx_t    rs1_q;
  reg_idx_t    rs2_q;
  word_t       rs1_data_q;
  word_t       rs2_data_q;
  word_t       imm_q;
  alu_ctrl_e   alu_ctrl_q;
  alu_src_e    alu_src_q;
  result_src_e result_src_q;
  data_size_e  data_size_q;

  word_t       op1;
  word_t       op2_reg;
  word_t       op2;
  word_t       alu_res;
  logic        zero;
  xcpt_e       xcpt;

  function automatic word_t fwd_mux(fwd_src_e sel, word_t rf_val, word_t c_val,
                                    word_t wb_val);
    word_t val;
    unique case (sel)
      FROM_CACHE: val = c_val;
      FROM_WB:    val = wb_val;
      default:    val = rf_val;
    endcase
    return val;
  endfunction

  // Control bits; a held op survives the squash raised by its own redirect
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_write_q <= 1'b0;
      mem_write_q <= 1'b0;
      is_branch_q <= 1'b0;
      is_jump_q   <= 1'b0;
    end else if (!stall) begin
      reg_write_q <= issue && !squash && reg_write;
      mem_write_q <= issue && !squash && mem_write;
      is_branch_q <= issue && !squash && is_branch;
      is_jump_q   <= issue && !squash && is_jump;
    end
  end

  always_ff @(posedge clk) begin
    if (stall) begin
      // Producers drain while held, so keep the resolved operands
      rs1_data_q <= op1;
      rs2_data_q <= op2_reg;
    end else begin
      pc_q         <= pc;
      rd_q         <= rd;
      rs1_q        <= rs1;
      rs2_q        <= rs2;
      rs1_data_q   <= rs1_data;
      rs2_data_q   <= rs2_data;
      imm_q        <= imm;
      alu_ctrl_q   <= alu_ctrl;
      alu_src_q    <= alu_src;
      result_src_q <= result_src;
      data_size_q  <= data_size;
    end
  end

  assign op1     = fwd_mux(fwd_src1, rs1_data_q, alu_res_c, result_wb);
  assign op2_reg = fwd_mux(fwd_src2, rs2_data_q, alu_res_c, result_wb);
  assign op2     = (alu_src_q == FROM_IMM) ? imm_q : op2_reg;

  alu u_alu (
    .src1   (op1),
    .src2   (op2),
    .ctrl   (alu_ctrl_q),
    .result (alu_res),
    .zero   (zero)
  );

  assign pc_src    = ((is_branch_q && zero) || is_jump_q) ? PC_TARGET : PC_SEQ;
  assign pc_target = pc_q + imm_q;
  assign ex_rs1    = rs1_q;
  assign ex_rs2    = rs2_q;

  // Store address check
  always_comb begin
    xcpt = NO_XCPT;
    if (mem_write_q && !stall) begin
      if (data_size_q == W && alu_res[1:0] != 2'b00) begin
        xcpt = MEM_UNALIGNED;
      end else if (alu_res < `PC_DATA) begin
        xcpt = ADDR_INVALID;
      end
    end
  end

  // Bubble into C while stalled
  assign res.reg_write  = reg_write_q && !stall;
  assign res.mem_write  = mem_write_q && !stall;
  assign res.rd         = rd_q;
  assign res.alu_res    = alu_res;
  assign res.pc_plus4   = pc_q + 4;
  assign res.result_src = result_src_q;
  assign res.write_data = op2_reg;
  assign res.data_size  = data_size_q;
  assign res.xcpt       = xcpt;

endmodule

/* design/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
  input  brisc_pkg::reg_idx_t ex_rs1,
  input  brisc_pkg::reg_idx_t ex_rs2,
  input  brisc_pkg::reg_idx_t c_rd,
  input  brisc_pkg::reg_idx_t wb_rd,
  input  logic                c_reg_write,
  input  logic                wb_reg_write,
  input  brisc_pkg::pc_src_e  pc_src,
  output brisc_pkg::fwd_src_e fwd_src1,
  output brisc_pkg::fwd_src_e fwd_src2,
  output logic                squash
);
  import brisc_pkg::*;

  // Newest producer wins, r0 is never bypassed
  function automatic fwd_src_e pick_src(reg_idx_t idx, reg_idx_t c_idx, logic c_we,
                                        reg_idx_t wb_idx, logic wb_we);
    fwd_src_e sel;
    sel = FROM_RF;
    if (idx != '0) begin
      if (c_we && c_idx == idx) begin
        sel = FROM_CACHE;
      end else if (wb_we && wb_idx == idx) begin
        sel = FROM_WB;
      end
    end
    return sel;
  endfunction

  assign fwd_src1 = pick_src(ex_rs1, c_rd, c_reg_write, wb_rd, wb_reg_write);
  assign fwd_src2 = pick_src(ex_rs2, c_rd, c_reg_write, wb_rd, wb_reg_write);

  // Kill the op entering execute behind a redirect
  assign squash = (pc_src == PC_TARGET);

endmodule

/* design/alu.sv */
`timescale 1ns/1ps

module alu (
  input  brisc_pkg::word_t     src1,
  input  brisc_pkg::word_t     src2,
  input  brisc_pkg::alu_ctrl_e ctrl,
  output brisc_pkg::word_t     result,
  output logic                 zero
);
  import brisc_pkg::*;

  localparam int SHAMT_W = $clog2($bits(word_t));

  logic [SHAMT_W-1:0] shamt;
  logic               lt;

  assign shamt = src2[SHAMT_W-1:0];
  assign lt    = $signed(src1) < $signed(src2);

  always_comb begin
    unique case (ctrl)
      ADD:     result = src1 + src2;
      SUB:     result = src1 - src2;
      AND:     result = src1 & src2;
      OR:      result = src1 | src2;
      XOR:     result = src1 ^ src2;
      SLT:     result = word_t'(lt);
      SLL:     result = src1 << shamt;
      SRL:     result = src1 >> shamt;
      default: result = '0;
    endcase
  end

  // Branch equality test relies on SUB
  assign zero = (result == '0);

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ps
`include "brisc_config.svh"

module reg_file (
  input  logic                clk,
  input  logic                arst_n,
  input  brisc_pkg::reg_idx_t rs1,
  input  brisc_pkg::reg_idx_t rs2,
  output brisc_pkg::word_t    rs1_data,
  output brisc_pkg::word_t    rs2_data,
  input  logic                wb_en,
  input  brisc_pkg::reg_idx_t wb_rd,
  input  brisc_pkg::word_t    wb_data
);
  import brisc_pkg::*;

  word_t regs [`NUM_REGS];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // Write-through so a same-cycle reader sees the new value
  assign rs1_data = (rs1 == '0) ? '0 :
                    (wb_en && wb_rd == rs1) ? wb_data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 :
                    (wb_en && wb_rd == rs2) ? wb_data : regs[rs2];

endmodule

/* design/ex_result_if.sv */
`timescale 1ns/1ps

interface ex_result_if;

  logic                    reg_write;
  brisc_pkg::reg_idx_t     rd;
  brisc_pkg::word_t        alu_res;
  brisc_pkg::word_t        pc_plus4;
  brisc_pkg::result_src_e  result_src;
  logic                    mem_write;
  brisc_pkg::word_t        write_data;
  brisc_pkg::data_size_e   data_size;
  brisc_pkg::xcpt_e        xcpt;

  // Execute side drives, commit side samples
  modport ex (
    output reg_write, rd, alu_res, pc_plus4, result_src,
    output mem_write, write_data, data_size, xcpt
  );

  modport cm (
    input reg_write, rd, alu_res, pc_plus4, result_src,
    input mem_write, write_data, data_size, xcpt
  );

endinterface

/* design/brisc_pkg.sv */
`include "brisc_config.svh"

package brisc_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`REG_BITS-1:0] reg_idx_t;

  // Operand bypass source
  typedef enum logic [1:0] {
    FROM_RF,
    FROM_CACHE,
    FROM_WB
  } fwd_src_e;

  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,
    SLL,
    SRL
  } alu_ctrl_e;

  typedef enum logic {FROM_REG, FROM_IMM} alu_src_e;

  typedef enum logic {RES_ALU, RES_PC4} result_src_e;

  typedef enum logic [1:0] {B, H, W} data_size_e;

  typedef enum logic [1:0] {NO_XCPT, MEM_UNALIGNED, ADDR_INVALID} xcpt_e;

  typedef enum logic {PC_SEQ, PC_TARGET} pc_src_e;

endpackage

/* design/brisc_config.svh */
`ifndef BRISC_CONFIG_SVH
`define BRISC_CONFIG_SVH

// Datapath and register file sizes
`define XLEN 32
`define REG_BITS 5
`define NUM_REGS 32

// Stores below this address fault
`define PC_DATA 32'h0000_0100

`endif
